// File: hw/fe_pkg.sv
// Front end shared definitions

package fe_pkg;

    //========================================
    // Widths
    //========================================

    // Instruction, address and immediate width
    localparam int xlen = 32;

    // Register index width for the 32 integer registers
    localparam int reg_idx_w = 5;

    typedef logic [xlen-1:0]      word_t;
    typedef logic [xlen/2-1:0]    half_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // Address of the first word fetched after reset
    localparam word_t boot_addr = 32'h0000_0000;

    //========================================
    // Encodings
    //========================================

    // Major opcodes in bits 6:0 of a full-length instruction
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_lui    = 7'b0110111;

    // ADD, ADDI and SUB all share this funct3 value
    localparam logic [2:0] funct3_add = 3'b000;

    // Bit 30 set in funct7 selects SUB over ADD
    localparam logic [6:0] funct7_sub = 7'b0100000;

    // Low two bits of a halfword that starts a 32-bit instruction
    // Any other value marks a compressed instruction
    localparam logic [1:0] rvc_quad_full = 2'b11;

    //========================================
    // Issue operations
    //========================================

    // ADDI issues as op_add with the immediate selected
    // LUI issues as op_lui and adds the immediate to x0
    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_lui = 2'd2
    } op_e;

endpackage : fe_pkg

// File: hw/front_end.sv
// Instruction front end top level

`timescale 1ns/1ps

module front_end (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             stall_i,
    input  logic             flush_i,
    input  fe_pkg::word_t    redirect_pc_i,
    input  logic             word_valid_i,
    input  fe_pkg::word_t    word_i,
    output logic             word_ready_o,
    output logic             issue_valid_o,
    output fe_pkg::word_t    issue_pc_o,
    output fe_pkg::op_e      issue_op_o,
    output fe_pkg::reg_idx_t issue_rd_o,
    output fe_pkg::reg_idx_t issue_rs1_o,
    output fe_pkg::reg_idx_t issue_rs2_o,
    output fe_pkg::word_t    issue_imm_o,
    output logic             issue_use_imm_o,
    output logic             issue_compressed_o,
    output logic             issue_illegal_o
);

    // One realigned instruction per cycle between the two stages
    stage_if i_stage ();

    // Stage 1 turns the word stream into whole instructions
    instr_realign i_realign (
        .clk_i         ( clk_i            ),
        .rst_n_i       ( rst_n_i          ),
        .stall_i       ( stall_i          ),
        .flush_i       ( flush_i          ),
        .redirect_pc_i ( redirect_pc_i    ),
        .word_valid_i  ( word_valid_i     ),
        .word_i        ( word_i           ),
        .word_ready_o  ( word_ready_o     ),
        .out           ( i_stage.producer )
    );

    // Stage 2 decodes and registers the issue packet
    instr_decoder i_decoder (
        .clk_i              ( clk_i              ),
        .rst_n_i            ( rst_n_i            ),
        .stall_i            ( stall_i            ),
        .flush_i            ( flush_i            ),
        .in                 ( i_stage.consumer   ),
        .issue_valid_o      ( issue_valid_o      ),
        .issue_pc_o         ( issue_pc_o         ),
        .issue_op_o         ( issue_op_o         ),
        .issue_rd_o         ( issue_rd_o         ),
        .issue_rs1_o        ( issue_rs1_o        ),
        .issue_rs2_o        ( issue_rs2_o        ),
        .issue_imm_o        ( issue_imm_o        ),
        .issue_use_imm_o    ( issue_use_imm_o    ),
        .issue_compressed_o ( issue_compressed_o ),
        .issue_illegal_o    ( issue_illegal_o    )
    );

endmodule : front_end

// File: hw/instr_decoder.sv
// Instruction decode and issue register

`timescale 1ns/1ps

module instr_decoder (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             stall_i,
    input  logic             flush_i,
    stage_if.consumer        in,
    output logic             issue_valid_o,
    output fe_pkg::word_t    issue_pc_o,
    output fe_pkg::op_e      issue_op_o,
    output fe_pkg::reg_idx_t issue_rd_o,
    output fe_pkg::reg_idx_t issue_rs1_o,
    output fe_pkg::reg_idx_t issue_rs2_o,
    output fe_pkg::word_t    issue_imm_o,
    output logic             issue_use_imm_o,
    output logic             issue_compressed_o,
    output logic             issue_illegal_o
);

    fe_pkg::word_t    exp_instr;
    logic             exp_illegal;
    fe_pkg::word_t    instr;

    // Decoded fields before the issue register
    fe_pkg::op_e      dec_op;
    fe_pkg::reg_idx_t dec_rd;
    fe_pkg::reg_idx_t dec_rs1;
    fe_pkg::reg_idx_t dec_rs2;
    fe_pkg::word_t    dec_imm;
    logic             dec_use_imm;
    logic             dec_illegal;

    rvc_expander i_expander (
        .half_i    ( in.instr[15:0] ),
        .instr_o   ( exp_instr      ),
        .illegal_o ( exp_illegal    )
    );

    // Compressed items are decoded in their expanded 32-bit form
    assign instr = in.compressed ? exp_instr : in.instr;

    //========================================
    // Decode
    //========================================

    always_comb begin : decode
        dec_op      = fe_pkg::op_add;
        dec_rd      = instr[11:7];
        dec_rs1     = instr[19:15];
        dec_rs2     = instr[24:20];
        dec_imm     = '0;
        dec_use_imm = 1'b0;
        dec_illegal = 1'b1;

        case (instr[6:0])
            fe_pkg::opc_op_imm: begin
                // Only ADDI, with the sign-extended I-immediate
                if (instr[14:12] == fe_pkg::funct3_add) begin
                    dec_rs2     = '0;
                    dec_imm     = {{20{instr[31]}}, instr[31:20]};
                    dec_use_imm = 1'b1;
                    dec_illegal = 1'b0;
                end
            end

            fe_pkg::opc_op: begin
                // Register-register ADD and SUB
                if (instr[14:12] == fe_pkg::funct3_add) begin
                    if (instr[31:25] == 7'b0000000) begin
                        dec_illegal = 1'b0;
                    end else if (instr[31:25] == fe_pkg::funct7_sub) begin
                        dec_op      = fe_pkg::op_sub;
                        dec_illegal = 1'b0;
                    end
                end
            end

            fe_pkg::opc_lui: begin
                // U-immediate added to x0
                dec_op      = fe_pkg::op_lui;
                dec_rs1     = '0;
                dec_rs2     = '0;
                dec_imm     = {instr[31:12], 12'h000};
                dec_use_imm = 1'b1;
                dec_illegal = 1'b0;
            end

            default: begin
                dec_illegal = 1'b1;
            end
        endcase

        // A rejected halfword makes the whole item illegal whatever its expansion looks like
        if (in.compressed && exp_illegal) begin
            dec_illegal = 1'b1;
        end

        // Illegal items carry no operation, registers or immediate
        if (dec_illegal) begin
            dec_op      = fe_pkg::op_add;
            dec_rd      = '0;
            dec_rs1     = '0;
            dec_rs2     = '0;
            dec_imm     = '0;
            dec_use_imm = 1'b0;
        end
    end : decode

    //========================================
    // Issue register
    //========================================

    always_ff @(posedge clk_i) begin : issue_reg
        if (!rst_n_i) begin
            issue_valid_o      <= 1'b0;
            issue_pc_o         <= '0;
            issue_op_o         <= fe_pkg::op_add;
            issue_rd_o         <= '0;
            issue_rs1_o        <= '0;
            issue_rs2_o        <= '0;
            issue_imm_o        <= '0;
            issue_use_imm_o    <= 1'b0;
            issue_compressed_o <= 1'b0;
            issue_illegal_o    <= 1'b0;
        end else if (flush_i) begin
            // Drop the pending packet, the payload is ignored while valid is low
            issue_valid_o <= 1'b0;
        end else if (!stall_i) begin
            issue_valid_o      <= in.valid;
            issue_pc_o         <= in.pc;
            issue_op_o         <= dec_op;
            issue_rd_o         <= dec_rd;
            issue_rs1_o        <= dec_rs1;
            issue_rs2_o        <= dec_rs2;
            issue_imm_o        <= dec_imm;
            issue_use_imm_o    <= dec_use_imm;
            issue_compressed_o <= in.compressed;
            issue_illegal_o    <= dec_illegal;
        end
    end : issue_reg

endmodule : instr_decoder

// File: hw/instr_realign.sv
// Instruction realign stage

`timescale 1ns/1ps

module instr_realign (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            stall_i,
    input  logic            flush_i,
    input  fe_pkg::word_t   redirect_pc_i,
    input  logic            word_valid_i,
    input  fe_pkg::word_t   word_i,
    output logic            word_ready_o,
    stage_if.producer       out
);

    // Address of the next word to be taken from the source
    fe_pkg::word_t word_pc;

    // Upper halfword left over from the previous word
    fe_pkg::half_t hold_half;
    fe_pkg::word_t hold_pc;
    logic          hold_valid;

    logic          held_full;
    logic          held_comp;
    logic          word_full;
    logic          word_take;

    // Next state of the realign step
    logic          emit_valid;
    fe_pkg::word_t emit_instr;
    fe_pkg::word_t emit_pc;
    logic          emit_comp;
    logic          hold_valid_nxt;
    logic          hold_load;

    //========================================
    // Intake handshake
    //========================================

    // The held halfword is either the start of a 32-bit instruction or a whole compressed one
    assign held_full = hold_valid && (hold_half[1:0] == fe_pkg::rvc_quad_full);
    assign held_comp = hold_valid && (hold_half[1:0] != fe_pkg::rvc_quad_full);
    assign word_full = (word_i[1:0] == fe_pkg::rvc_quad_full);

    // A held compressed instruction drains first, so no new word fits this cycle
    assign word_ready_o = !stall_i && !flush_i && !held_comp;
    assign word_take    = word_valid_i && word_ready_o;

    //========================================
    // Realign step
    //========================================

    always_comb begin : realign_select
        emit_valid     = 1'b0;
        emit_instr     = word_i;
        emit_pc        = word_pc;
        emit_comp      = 1'b0;
        hold_valid_nxt = hold_valid;
        hold_load      = 1'b0;

        if (held_comp) begin
            // Issue the leftover compressed halfword on its own
            emit_valid     = 1'b1;
            emit_instr     = {16'h0000, hold_half};
            emit_pc        = hold_pc;
            emit_comp      = 1'b1;
            hold_valid_nxt = 1'b0;
        end else if (word_take) begin
            emit_valid = 1'b1;

            if (held_full) begin
                // Boundary crossing: held half is the low part, new low half the upper part
                emit_instr     = {word_i[15:0], hold_half};
                emit_pc        = hold_pc;
                hold_valid_nxt = 1'b1;
                hold_load      = 1'b1;
            end else if (word_full) begin
                // Aligned 32-bit instruction fills the whole word
                hold_valid_nxt = 1'b0;
            end else begin
                // Compressed low half, the upper half waits for the next cycle
                emit_instr     = {16'h0000, word_i[15:0]};
                emit_comp      = 1'b1;
                hold_valid_nxt = 1'b1;
                hold_load      = 1'b1;
            end
        end
        // A held full-length start with no word available emits nothing
    end : realign_select

    //========================================
    // State registers
    //========================================

    always_ff @(posedge clk_i) begin : realign_ctrl
        if (!rst_n_i) begin
            word_pc    <= fe_pkg::boot_addr;
            hold_valid <= 1'b0;
            out.valid  <= 1'b0;
        end else if (flush_i) begin
            // Restart the word stream at the redirect target
            word_pc    <= redirect_pc_i;
            hold_valid <= 1'b0;
            out.valid  <= 1'b0;
        end else if (!stall_i) begin
            if (word_take) begin
                word_pc <= word_pc + 32'd4;
            end
            hold_valid <= hold_valid_nxt;
            out.valid  <= emit_valid;
        end
    end : realign_ctrl

    always_ff @(posedge clk_i) begin : realign_data
        if (!rst_n_i) begin
            out.instr      <= '0;
            out.pc         <= '0;
            out.compressed <= 1'b0;
        end else if (!stall_i) begin
            out.instr      <= emit_instr;
            out.pc         <= emit_pc;
            out.compressed <= emit_comp;
        end
    end : realign_data

    // The upper halfword always sits two bytes above the word just taken
    always_ff @(posedge clk_i) begin : hold_data
        if (hold_load) begin
            hold_half <= word_i[31:16];
            hold_pc   <= word_pc + 32'd2;
        end
    end : hold_data

endmodule : instr_realign

// File: hw/rvc_expander.sv
// Compressed instruction expander

`timescale 1ns/1ps

module rvc_expander (
    input  fe_pkg::half_t half_i,
    output fe_pkg::word_t instr_o,
    output logic          illegal_o
);

    // Register fields shared by the CI and CR formats
    fe_pkg::reg_idx_t rd;
    fe_pkg::reg_idx_t rs2;

    // CI immediate, sign extended from bit 12 to twelve bits
    logic [11:0]      imm12;

    logic [1:0]       quadrant;
    logic [2:0]       funct3;

    assign quadrant = half_i[1:0];
    assign funct3   = half_i[15:13];
    assign rd       = half_i[11:7];
    assign rs2      = half_i[6:2];
    assign imm12    = {{6{half_i[12]}}, half_i[12], half_i[6:2]};

    //========================================
    // Expansion
    //========================================

    always_comb begin : expand
        instr_o   = '0;
        illegal_o = 1'b1;

        case (quadrant)
            2'b01: begin
                // Quadrant 1 holds C.ADDI (funct3 000) and C.LI (funct3 010)
                if (funct3 == 3'b000) begin
                    // ADDI rd, rd, imm
                    instr_o   = {imm12, rd, fe_pkg::funct3_add, rd, fe_pkg::opc_op_imm};
                    illegal_o = 1'b0;
                end else if (funct3 == 3'b010) begin
                    // ADDI rd, x0, imm
                    instr_o   = {imm12, 5'd0, fe_pkg::funct3_add, rd, fe_pkg::opc_op_imm};
                    illegal_o = 1'b0;
                end
            end

            2'b10: begin
                // Quadrant 2 funct3 100 holds C.MV and C.ADD, told apart by bit 12
                // A zero rs2 there encodes a jump or EBREAK, which stay unsupported
                if (funct3 == 3'b100 && rs2 != 5'd0) begin
                    if (!half_i[12]) begin
                        // ADD rd, x0, rs2
                        instr_o = {7'b0000000, rs2, 5'd0, fe_pkg::funct3_add, rd,
                                   fe_pkg::opc_op};
                    end else begin
                        // ADD rd, rd, rs2
                        instr_o = {7'b0000000, rs2, rd, fe_pkg::funct3_add, rd,
                                   fe_pkg::opc_op};
                    end
                    illegal_o = 1'b0;
                end
            end

            default: begin
                // Quadrant 0 is not supported here and 11 is not compressed at all
                illegal_o = 1'b1;
            end
        endcase
    end : expand

endmodule : rvc_expander

// File: hw/stage_if.sv
// Realign to decode stage link

`timescale 1ns/1ps

interface stage_if;

    // High when instr and pc hold an instruction to decode
    logic             valid;

    // Full instruction, or a compressed one in the low halfword
    fe_pkg::word_t    instr;

    // Address of the first halfword of the instruction
    fe_pkg::word_t    pc;

    // High when only instr[15:0] is meaningful
    logic             compressed;

    // The realign stage owns the register behind these signals
    modport producer (
        output valid,
        output instr,
        output pc,
        output compressed
    );

    // The decode stage only samples them
    modport consumer (
        input valid,
        input instr,
        input pc,
        input compressed
    );

endinterface : stage_if

// File: tb.f
hw/fe_pkg.sv
hw/stage_if.sv
hw/instr_realign.sv
hw/rvc_expander.sv
hw/instr_decoder.sv
hw/front_end.sv
tests/front_end_assert.sv
tests/front_end_tb.sv

// File: tests/front_end_assert.sv
// Front end protocol assertions

`timescale 1ns/1ps

module front_end_assert (
    input logic             clk_i,
    input logic             rst_n_i,
    input logic             stall_i,
    input logic             flush_i,
    input logic             word_ready_o,
    input logic             issue_valid_o,
    input fe_pkg::word_t    issue_pc_o,
    input fe_pkg::op_e      issue_op_o,
    input fe_pkg::reg_idx_t issue_rd_o,
    input fe_pkg::reg_idx_t issue_rs1_o,
    input fe_pkg::reg_idx_t issue_rs2_o,
    input fe_pkg::word_t    issue_imm_o,
    input logic             issue_use_imm_o,
    input logic             issue_compressed_o,
    input logic             issue_illegal_o
);

    // A reset edge always leaves the issue register empty
    a_reset_clears: assert property (@(posedge clk_i) !rst_n_i |=> !issue_valid_o)
        else $error("issue_valid_o high in the cycle after reset");

    // No word may enter while the pipeline is frozen
    a_stall_ready: assert property (@(posedge clk_i) stall_i |-> !word_ready_o)
        else $error("word_ready_o high while stall_i is high");

    // A stalled edge without reset or flush keeps the whole issue packet
    a_stall_hold: assert property (@(posedge clk_i)
        (rst_n_i && stall_i && !flush_i) |=>
            $stable(issue_valid_o) && $stable(issue_pc_o) && $stable(issue_op_o) &&
            $stable(issue_rd_o) && $stable(issue_rs1_o) && $stable(issue_rs2_o) &&
            $stable(issue_imm_o) && $stable(issue_use_imm_o) &&
            $stable(issue_compressed_o) && $stable(issue_illegal_o))
        else $error("issue outputs changed across a stalled cycle");

endmodule : front_end_assert

bind front_end front_end_assert i_assert (.*);

// File: tests/front_end_tb.sv
// Front end testbench

`timescale 1ns/1ps

module front_end_tb;

    localparam int num_tests = 6;

    // Expected issue packet, built from the realign and decode rules
    typedef struct packed {
        fe_pkg::word_t    pc;
        fe_pkg::op_e      op;
        fe_pkg::reg_idx_t rd;
        fe_pkg::reg_idx_t rs1;
        fe_pkg::reg_idx_t rs2;
        fe_pkg::word_t    imm;
        logic             use_imm;
        logic             comp;
        logic             illegal;
    } pkt_t;

    logic             clk_i = 1'b0;
    logic             rst_n_i, stall_i, flush_i, word_valid_i, word_ready_o;
    fe_pkg::word_t    redirect_pc_i, word_i, issue_pc_o, issue_imm_o;
    logic             issue_valid_o, issue_use_imm_o, issue_compressed_o, issue_illegal_o;
    fe_pkg::op_e      issue_op_o;
    fe_pkg::reg_idx_t issue_rd_o, issue_rs1_o, issue_rs2_o;

    int   errors, passed, failed;
    bit   checking;
    pkt_t exp_q [$];

    // Issue outputs at the last falling edge, and whether the edge after it was stalled
    logic [84:0] last_issue;
    bit          last_stalled = 1'b0;

    //========================================
    // Stimulus table
    //========================================

    // Compressed entries sit in the low halfword with the upper halfword zero
    logic [31:0] tab_instr [num_tests][8] = '{
        '{32'h00500093, 32'hFFF08113, 32'h002081B3, 32'h40118233, 32'h123452B7, 0, 0, 0},
        '{32'h0000440D, 32'h00001479, 32'h000084A2, 32'h000094A2, 0, 0, 0, 0},
        '{32'h0000440D, 32'h00500093, 32'h002081B3, 32'h40118233, 32'h000084A2, 0, 0, 0},
        '{32'h00500093, 32'h00001479, 32'h123452B7, 32'h000094A2, 32'h40118233,
          32'h000084A2, 32'h0000440D, 0},
        '{32'h123452B7, 32'h0000440D, 32'h002081B3, 32'h000094A2, 0, 0, 0, 0},
        '{32'h00500093, 32'h00000073, 32'h0000440D, 32'h00000000, 32'h00008082,
          32'h002081B3, 32'h000084A2, 0}
    };
    int          tab_len      [num_tests] = '{5, 4, 5, 7, 4, 7};
    bit          tab_flush    [num_tests] = '{0, 1, 1, 1, 1, 1};
    logic [31:0] tab_redirect [num_tests] = '{0, 32'h100, 32'h200, 32'h300, 32'h400, 32'h500};
    // Aligned ADDI words fed before the flush, to be thrown away by it
    int          tab_pre      [num_tests] = '{0, 0, 0, 0, 3, 0};
    bit          tab_rnd      [num_tests] = '{0, 0, 0, 1, 1, 0};
    string       tab_name     [num_tests] = '{"full aligned", "compressed", "crossing",
                                              "stalls and gaps", "mid-stream flush", "illegal"};

    front_end i_dut (
        .clk_i              ( clk_i              ),
        .rst_n_i            ( rst_n_i            ),
        .stall_i            ( stall_i            ),
        .flush_i            ( flush_i            ),
        .redirect_pc_i      ( redirect_pc_i      ),
        .word_valid_i       ( word_valid_i       ),
        .word_i             ( word_i             ),
        .word_ready_o       ( word_ready_o       ),
        .issue_valid_o      ( issue_valid_o      ),
        .issue_pc_o         ( issue_pc_o         ),
        .issue_op_o         ( issue_op_o         ),
        .issue_rd_o         ( issue_rd_o         ),
        .issue_rs1_o        ( issue_rs1_o        ),
        .issue_rs2_o        ( issue_rs2_o        ),
        .issue_imm_o        ( issue_imm_o        ),
        .issue_use_imm_o    ( issue_use_imm_o    ),
        .issue_compressed_o ( issue_compressed_o ),
        .issue_illegal_o    ( issue_illegal_o    )
    );

    always #10 clk_i = ~clk_i;

    //========================================
    // Reference model
    //========================================

    function automatic pkt_t expect_pkt(input logic [31:0] ins, input logic [31:0] pc);
        pkt_t        p;
        logic [15:0] h;
        p         = '0;
        h         = ins[15:0];
        p.pc      = pc;
        p.comp    = (ins[1:0] != fe_pkg::rvc_quad_full);
        p.illegal = 1'b1;
        if (p.comp) begin
            if (h[1:0] == 2'b01 && (h[15:13] == 3'b000 || h[15:13] == 3'b010)) begin
                // C.ADDI adds to rd itself, C.LI adds to x0
                p.rd      = h[11:7];
                p.rs1     = (h[15:13] == 3'b000) ? h[11:7] : 5'd0;
                p.imm     = {{26{h[12]}}, h[12], h[6:2]};
                p.use_imm = 1'b1;
                p.illegal = 1'b0;
            end else if (h[1:0] == 2'b10 && h[15:13] == 3'b100 && h[6:2] != 5'd0) begin
                // Bit 12 picks C.ADD over C.MV
                p.rd      = h[11:7];
                p.rs1     = h[12] ? h[11:7] : 5'd0;
                p.rs2     = h[6:2];
                p.illegal = 1'b0;
            end
        end else if (ins[6:0] == fe_pkg::opc_op_imm && ins[14:12] == fe_pkg::funct3_add) begin
            p.rd      = ins[11:7];
            p.rs1     = ins[19:15];
            p.imm     = {{20{ins[31]}}, ins[31:20]};
            p.use_imm = 1'b1;
            p.illegal = 1'b0;
        end else if (ins[6:0] == fe_pkg::opc_op && ins[14:12] == fe_pkg::funct3_add &&
                     (ins[31:25] == 7'd0 || ins[31:25] == fe_pkg::funct7_sub)) begin
            p.op      = ins[30] ? fe_pkg::op_sub : fe_pkg::op_add;
            p.rd      = ins[11:7];
            p.rs1     = ins[19:15];
            p.rs2     = ins[24:20];
            p.illegal = 1'b0;
        end else if (ins[6:0] == fe_pkg::opc_lui) begin
            p.op      = fe_pkg::op_lui;
            p.rd      = ins[11:7];
            p.imm     = {ins[31:12], 12'h000};
            p.use_imm = 1'b1;
            p.illegal = 1'b0;
        end
        return p;
    endfunction

    //========================================
    // Drivers and checks
    //========================================

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    // Offer one word, with random gaps and stalls when asked, until it is taken
    task automatic send_word(input logic [31:0] w, input bit rnd);
        logic taken;
        taken = 1'b0;
        while (rnd && ($urandom % 4 == 0)) begin
            word_valid_i = 1'b0;
            stall_i      = ($urandom % 3 == 0);
            next_cycle();
        end
        word_valid_i = 1'b1;
        word_i       = w;
        while (!taken) begin
            stall_i = rnd && ($urandom % 4 == 0);
            @(negedge clk_i);
            taken = word_ready_o;
            next_cycle();
        end
        word_valid_i = 1'b0;
        stall_i      = 1'b0;
    endtask

    task automatic apply_flush(input logic [31:0] addr);
        flush_i       = 1'b1;
        redirect_pc_i = addr;
        next_cycle();
        flush_i       = 1'b0;
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("Fail at %0t: field %s got %h expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    // A shown packet is consumed at the next edge unless that edge stalls or flushes
    always @(negedge clk_i) begin : collect
        pkt_t        want;
        logic [84:0] issue_now;
        issue_now = {issue_valid_o, issue_pc_o, issue_op_o, issue_rd_o, issue_rs1_o,
                     issue_rs2_o, issue_imm_o, issue_use_imm_o, issue_compressed_o,
                     issue_illegal_o};
        // A stalled edge must leave every issue output as it was
        if (last_stalled && issue_now !== last_issue) begin
            $display("Fail at %0t: issue outputs changed across a stalled cycle", $time);
            errors++;
        end
        last_stalled = rst_n_i && stall_i && !flush_i;
        last_issue   = issue_now;
        if (rst_n_i && stall_i && word_ready_o) begin
            $display("Fail at %0t: word_ready_o high while stall_i is high", $time);
            errors++;
        end
        if (rst_n_i && checking && issue_valid_o && !stall_i && !flush_i) begin
            if (exp_q.size() == 0) begin
                $display("Fail at %0t: unexpected packet at pc %h", $time, issue_pc_o);
                errors++;
            end else begin
                want = exp_q.pop_front();
                check_field("pc", issue_pc_o, want.pc);
                check_field("op", issue_op_o, want.op);
                check_field("rd", issue_rd_o, want.rd);
                check_field("rs1", issue_rs1_o, want.rs1);
                check_field("rs2", issue_rs2_o, want.rs2);
                check_field("imm", issue_imm_o, want.imm);
                check_field("use_imm", issue_use_imm_o, want.use_imm);
                check_field("compressed", issue_compressed_o, want.comp);
                check_field("illegal", issue_illegal_o, want.illegal);
            end
        end
    end : collect

    //========================================
    // Test sequence
    //========================================

    initial begin : main
        int          t, j, n, start_err;
        logic [31:0] ins, pc;
        logic [15:0] halves [$];
        void'($urandom(36026));
        rst_n_i       = 1'b0;
        stall_i       = 1'b0;
        flush_i       = 1'b0;
        redirect_pc_i = '0;
        word_valid_i  = 1'b0;
        word_i        = '0;
        errors        = 0;
        passed        = 0;
        failed        = 0;
        checking      = 1'b1;
        repeat (8) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        if (word_ready_o !== 1'b1 || issue_valid_o !== 1'b0) begin
            $display("Fail at %0t: ready or valid wrong after reset", $time);
            errors++;
        end
        for (t = 0; t < num_tests; t++) begin
            start_err = errors;
            // Packets of the discarded prefix are not compared
            checking = (tab_pre[t] == 0);
            for (j = 0; j < tab_pre[t]; j++) begin
                send_word(32'h00500093, 1'b0);
            end
            if (tab_flush[t]) begin
                apply_flush(tab_redirect[t]);
            end
            checking = 1'b1;
            pc = tab_flush[t] ? tab_redirect[t] : fe_pkg::boot_addr;
            halves.delete();
            for (j = 0; j < tab_len[t]; j++) begin
                ins = tab_instr[t][j];
                exp_q.push_back(expect_pkt(ins, pc));
                halves.push_back(ins[15:0]);
                if (ins[1:0] == fe_pkg::rvc_quad_full) begin
                    halves.push_back(ins[31:16]);
                end
                pc += (ins[1:0] == fe_pkg::rvc_quad_full) ? 32'd4 : 32'd2;
            end
            // Low halfword first, so a 32-bit instruction may straddle two words
            for (j = 0; j < halves.size(); j += 2) begin
                send_word({halves[j+1], halves[j]}, tab_rnd[t]);
            end
            n = 0;
            while (exp_q.size() != 0 && n < 100) begin
                next_cycle();
                n++;
            end
            if (exp_q.size() != 0) begin
                $display("test %0d (%s) timed out with %0d packets never issued",
                         t, tab_name[t], exp_q.size());
                exp_q.delete();
                errors++;
            end
            if (errors == start_err) begin
                passed++;
                $display("test %0d (%s) ok", t, tab_name[t]);
            end else begin
                failed++;
                $display("test %0d (%s) failed with %0d errors", t, tab_name[t],
                         errors - start_err);
            end
        end
        // A few idle cycles so that a stray extra packet still gets caught
        repeat (6) next_cycle();
        $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end : main

    initial begin : watchdog
        int total, k;
        total = 0;
        for (k = 0; k < num_tests; k++) begin
            total += tab_len[k];
        end
        repeat (total * 40 + 200) @(posedge clk_i);
        $display("watchdog expired after %0d cycles, the run did not finish", total * 40 + 200);
        $display("** FAIL **");
        $finish;
    end : watchdog

endmodule : front_end_tb
